/* include/fb_macros.svh */
// framebuffer subsystem sizes
// framebuffer geometry, coordinate widths and shrunk display timing
`ifndef FB_MACROS_SVH
`define FB_MACROS_SVH

// framebuffer size in pixels
`define FB_WIDTH        32
`define FB_HEIGHT       24
`define FB_PIXELS       (`FB_WIDTH * `FB_HEIGHT)  // 768 entries

`define CORDW           8   // signed coordinate width
`define CIDXW           2   // colour index width

// horizontal timing, active area matches the framebuffer
`define H_ACTIVE        32
`define H_SYNC_START    34
`define H_SYNC_END      37  // sync high from start up to end-1
`define H_TOTAL         40

`define V_ACTIVE        24  // vertical timing in lines
`define V_SYNC_START    25
`define V_SYNC_END      26
`define V_TOTAL         28
`endif

/* src/draw_pkg.sv */
// draw side types
// coordinates, colour index and framebuffer address for the draw path
`include "fb_macros.svh"

package draw_pkg;

    // signed so clipping can see off-screen endpoints
    typedef logic signed [`CORDW-1:0] coord_t;

    typedef logic [`CIDXW-1:0] cidx_t;  // palette index per pixel

    // linear address, row * width + column
    typedef logic [$clog2(`FB_PIXELS)-1:0] fb_addr_t;

endpackage

/* src/display_pkg.sv */
// display side types
// 12-bit rgb colour, three channels of 4 bits

package display_pkg;

    localparam int CHANW = 4;  // bits per channel

    typedef logic [CHANW-1:0] chan_t;

    // packed as {r, g, b}, red in the top channel
    typedef logic [3*CHANW-1:0] colr_t;

endpackage

/* src/bram_sdp.sv */
// simple dual-port ram
// one write port, one registered read port, payload set by type parameter
`timescale 1ns/10ps

module bram_sdp #(
    parameter type DATA_T = logic,  // payload
    parameter int  DEPTH  = 4       // entries
) (
    input  logic                     clk_sys,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr_write,
    input  logic [$clog2(DEPTH)-1:0] addr_read,
    input  DATA_T                    data_in,
    output DATA_T                    data_out
);

    DATA_T mem [DEPTH];

    // power-up content all zero, undrawn pixels read as index 0
    initial begin
        for (int i = 0; i < DEPTH; i++) mem[i] = '0;
    end

    always_ff @(posedge clk_sys) begin
        if (we) mem[addr_write] <= data_in;
        data_out <= mem[addr_read];  // old data on same-address collision
    end
endmodule

/* src/render_line.sv */
// bresenham line renderer
// takes two endpoints, emits one pixel coordinate per cycle, both ends included
`timescale 1ns/10ps
`include "fb_macros.svh"

module render_line (
    input  logic             clk_sys,
    input  logic             rst_sys,
    input  logic             start,     // one-cycle pulse, taken only when idle
    input  draw_pkg::coord_t x0,
    input  draw_pkg::coord_t y0,
    input  draw_pkg::coord_t x1,
    input  draw_pkg::coord_t y1,
    input  draw_pkg::cidx_t  cidx,
    output draw_pkg::coord_t px,
    output draw_pkg::coord_t py,
    output draw_pkg::cidx_t  pix_cidx,
    output logic             pix_valid,
    output logic             busy,
    output logic             done
);

    localparam int ERRW = `CORDW + 3;  // room for 2*err over full coord span

    typedef enum logic [1:0] {IDLE, INIT, DRAW} state_t;
    state_t state;

    draw_pkg::coord_t xa, ya, xb, yb;  // ordered endpoints, ya <= yb
    draw_pkg::coord_t x, y;            // current pixel
    draw_pkg::cidx_t  cidx_r;
    logic             x_right;         // x steps up when set
    logic             swap, last, step_x, step_y;
    logic signed [ERRW-1:0] dx, dy, err, e2, err_next, dx_abs, dy_neg;

    always_comb begin
        swap   = (y0 > y1) || ((y0 == y1) && (x0 > x1));  // y increasing, else x
        dx_abs = (xb > xa) ? ERRW'(xb) - ERRW'(xa) : ERRW'(xa) - ERRW'(xb);
        dy_neg = ERRW'(ya) - ERRW'(yb);  // never positive after ordering
        last   = (x == xb) && (y == yb);
        e2     = err <<< 1;
        step_x = (e2 >= dy);
        step_y = (e2 <= dx);
        err_next = err;
        if (step_x) err_next = err_next + dy;
        if (step_y) err_next = err_next + dx;
    end

    always_ff @(posedge clk_sys) begin
        done <= 1'b0;
        case (state)
            IDLE: if (start) begin
                xa     <= swap ? x1 : x0;
                ya     <= swap ? y1 : y0;
                xb     <= swap ? x0 : x1;
                yb     <= swap ? y0 : y1;
                cidx_r <= cidx;
                state  <= INIT;
            end
            INIT: begin  // slopes from latched endpoints
                x       <= xa;
                y       <= ya;
                x_right <= (xb > xa);
                dx      <= dx_abs;
                dy      <= dy_neg;
                err     <= dx_abs + dy_neg;
                state   <= DRAW;
            end
            DRAW: begin
                if (last) begin
                    state <= IDLE;
                    done  <= 1'b1;  // cycle after final pixel
                end else begin
                    if (step_x) x <= x_right ? x + draw_pkg::coord_t'(1) : x - draw_pkg::coord_t'(1);
                    if (step_y) y <= y + draw_pkg::coord_t'(1);
                    err <= err_next;
                end
            end
            default: state <= IDLE;
        endcase
        if (rst_sys) begin
            state <= IDLE;
            done  <= 1'b0;
        end
    end

    assign busy      = (state != IDLE);  // init cycle plus one per pixel
    assign pix_valid = (state == DRAW);
    assign px        = x;
    assign py        = y;
    assign pix_cidx  = cidx_r;
endmodule

/* src/bitmap_addr.sv */
// bitmap address pipeline
// clips pixel coordinates and turns them into a framebuffer write, 2 cycles
`timescale 1ns/10ps
`include "fb_macros.svh"

module bitmap_addr (
    input  logic               clk_sys,
    input  logic               rst_sys,
    input  draw_pkg::coord_t   px,
    input  draw_pkg::coord_t   py,
    input  logic               pix_valid,
    input  draw_pkg::cidx_t    pix_cidx,
    output logic               we,
    output draw_pkg::fb_addr_t addr,
    output draw_pkg::cidx_t    data
);

    logic               valid_s1, in_s1;  // stage 1 control
    draw_pkg::fb_addr_t row_s1, col_s1;
    draw_pkg::cidx_t    cidx_s1;

    always_ff @(posedge clk_sys) begin
        // stage 1: clip and row product
        valid_s1 <= pix_valid;
        in_s1    <= (px >= 0) && (px < `FB_WIDTH) && (py >= 0) && (py < `FB_HEIGHT);
        row_s1   <= draw_pkg::fb_addr_t'($unsigned(py)) * draw_pkg::fb_addr_t'(`FB_WIDTH);
        col_s1   <= draw_pkg::fb_addr_t'($unsigned(px));  // junk if clipped, we drops
        cidx_s1  <= pix_cidx;
        // stage 2: add column
        we   <= valid_s1 && in_s1;  // off-screen never writes, so no wraparound
        addr <= row_s1 + col_s1;
        data <= cidx_s1;
        if (rst_sys) begin
            valid_s1 <= 1'b0;
            we       <= 1'b0;
        end
    end
endmodule

/* src/display_scan.sv */
// display scanner
// position counters, active-high syncs, framebuffer read address and
// a 2-deep delay line that lines the syncs up with the colour pipeline
`timescale 1ns/10ps
`include "fb_macros.svh"

module display_scan (
    input  logic               clk_sys,
    input  logic               rst_sys,
    output draw_pkg::fb_addr_t addr_read,
    output logic               hsync,
    output logic               vsync,
    output logic               de
);

    localparam int SXW = $clog2(`H_TOTAL);
    localparam int SYW = $clog2(`V_TOTAL);
    localparam int LAT = 2;  // fb read + palette read

    logic [SXW-1:0] sx;  // column, includes blanking
    logic [SYW-1:0] sy;  // line
    logic           active, hs, vs;
    logic [LAT-1:0] de_q, hs_q, vs_q;  // bit 0 enters, top bit leaves

    // raster counters, one pixel per clock
    always_ff @(posedge clk_sys) begin
        if (sx == SXW'(`H_TOTAL - 1)) begin
            sx <= '0;
            sy <= (sy == SYW'(`V_TOTAL - 1)) ? '0 : sy + 1'b1;  // wrap at frame end
        end else begin
            sx <= sx + 1'b1;
        end
        if (rst_sys) begin
            sx <= '0;
            sy <= '0;
        end
    end

    always_comb begin
        active = (sx < SXW'(`H_ACTIVE)) && (sy < SYW'(`V_ACTIVE));
        hs = (sx >= SXW'(`H_SYNC_START)) && (sx < SXW'(`H_SYNC_END));
        vs = (sy >= SYW'(`V_SYNC_START)) && (sy < SYW'(`V_SYNC_END));
        // row * width + column, parked at 0 in blanking
        addr_read = active ? draw_pkg::fb_addr_t'(sy) * draw_pkg::fb_addr_t'(`FB_WIDTH)
                             + draw_pkg::fb_addr_t'(sx)
                           : '0;
    end

    // delay line matched to memory latency
    always_ff @(posedge clk_sys) begin
        de_q <= {de_q[LAT-2:0], active};
        hs_q <= {hs_q[LAT-2:0], hs};
        vs_q <= {vs_q[LAT-2:0], vs};
        if (rst_sys) begin
            de_q <= '0;
            hs_q <= '0;
            vs_q <= '0;
        end
    end

    assign de    = de_q[LAT-1];
    assign hsync = hs_q[LAT-1];
    assign vsync = vs_q[LAT-1];
endmodule

/* src/line_demo_top.sv */
// line demo top level
// draw path writes the framebuffer while the scan path reads it through the palette
`timescale 1ns/10ps
`include "fb_macros.svh"

module line_demo_top (
    input  logic                clk_sys,
    input  logic                rst_sys,
    input  logic                start,
    input  draw_pkg::coord_t    x0,
    input  draw_pkg::coord_t    y0,
    input  draw_pkg::coord_t    x1,
    input  draw_pkg::coord_t    y1,
    input  draw_pkg::cidx_t     cidx,
    output logic                busy,
    output logic                done,
    input  logic                pal_we,    // palette write port
    input  draw_pkg::cidx_t     pal_idx,
    input  display_pkg::colr_t  pal_colr,
    output logic                hsync,
    output logic                vsync,
    output logic                de,
    output display_pkg::chan_t  r,
    output display_pkg::chan_t  g,
    output display_pkg::chan_t  b
);

    draw_pkg::coord_t   px, py;  // renderer to address pipeline
    draw_pkg::cidx_t    pix_cidx;
    logic               pix_valid;
    logic               fb_we;
    draw_pkg::fb_addr_t fb_addr_write, fb_addr_read;
    draw_pkg::cidx_t    fb_data_write, fb_data_read;
    display_pkg::colr_t pal_out;  // already aligned with de

    render_line render_line0 (
        .clk_sys, .rst_sys, .start,
        .x0, .y0, .x1, .y1, .cidx,
        .px, .py, .pix_cidx, .pix_valid,
        .busy, .done
    );

    bitmap_addr bitmap_addr0 (
        .clk_sys, .rst_sys,
        .px, .py, .pix_valid, .pix_cidx,
        .we(fb_we), .addr(fb_addr_write), .data(fb_data_write)
    );

    display_scan display_scan0 (
        .clk_sys, .rst_sys,
        .addr_read(fb_addr_read),
        .hsync, .vsync, .de
    );

    // one colour index per pixel
    bram_sdp #(.DATA_T(draw_pkg::cidx_t), .DEPTH(`FB_PIXELS)) fb_mem (
        .clk_sys, .we(fb_we),
        .addr_write(fb_addr_write), .addr_read(fb_addr_read),
        .data_in(fb_data_write), .data_out(fb_data_read)
    );

    // palette, indexed straight by framebuffer output
    bram_sdp #(.DATA_T(display_pkg::colr_t), .DEPTH(2 ** `CIDXW)) pal_mem (
        .clk_sys, .we(pal_we),
        .addr_write(pal_idx), .addr_read(fb_data_read),
        .data_in(pal_colr), .data_out(pal_out)
    );

    assign {r, g, b} = de ? pal_out : '0;  // black in blanking
endmodule

/* verif/line_demo_chk.sv */
// line demo checker
// handshake and sync assertions bound into the top level
`timescale 1ns/10ps

module line_demo_chk (
    input logic               clk_sys,
    input logic               rst_sys,
    input logic               busy,
    input logic               done,
    input logic               de,
    input logic               hsync,
    input display_pkg::chan_t r,
    input display_pkg::chan_t g,
    input display_pkg::chan_t b
);

    int fail_count = 0;  // failed assertions so far

    reset_idle: assert property (@(posedge clk_sys) rst_sys |=> !busy && !done)
        else begin
            fail_count++;
            $error("busy or done high after reset");
        end

    // done marks busy falling
    done_on_fall: assert property (@(posedge clk_sys) disable iff (rst_sys)
        done |-> !busy && $past(busy))
        else begin
            fail_count++;
            $error("done without busy falling");
        end

    done_single: assert property (@(posedge clk_sys) disable iff (rst_sys)
        done |=> !done)
        else begin
            fail_count++;
            $error("done longer than one cycle");
        end

    blank_black: assert property (@(posedge clk_sys) disable iff (rst_sys)
        !de |-> (r == '0 && g == '0 && b == '0))
        else begin
            fail_count++;
            $error("colour outside active area");
        end

    hsync_blank: assert property (@(posedge clk_sys) disable iff (rst_sys)
        de |-> !hsync)
        else begin
            fail_count++;
            $error("hsync inside active area");
        end
endmodule

bind line_demo_top line_demo_chk chk0 (
    .clk_sys, .rst_sys, .busy, .done, .de, .hsync, .r, .g, .b
);

/* verif/line_demo_tb.sv */
// line demo testbench
// programs the palette, draws lines from the vectors file, captures a frame and checks it
`timescale 1ns/10ps
`include "fb_macros.svh"

module line_demo_tb;

    logic               clk_sys, rst_sys, start, pal_we;
    draw_pkg::coord_t   x0, y0, x1, y1;
    draw_pkg::cidx_t    cidx, pal_idx;
    display_pkg::colr_t pal_colr;
    logic               busy, done, hsync, vsync, de;
    display_pkg::chan_t r, g, b;

    logic [15:0]        vec [0:255];          // raw vector words
    int                 shadow [`FB_PIXELS];  // expected colour index per pixel
    display_pkg::colr_t pal_model [4];
    display_pkg::colr_t frame [`FB_PIXELS];   // captured colours in raster order
    int                 busy_cycles;          // busy length of the accepted line

    line_demo_top dut0 (.*);

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    // restarts only on a start the renderer accepts
    always @(negedge clk_sys) begin
        if (rst_sys || (start && !busy))
            busy_cycles = 0;
        else if (busy)
            busy_cycles++;
    end

    task automatic check(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic timed_out(input string what);
        $display("TIMEOUT: %s", what);
        $display("Regression failed");
        $fatal(1, "stopped on timeout");
    endtask

    // 8-bit signed field of a vector word
    function automatic int field(input logic [15:0] w);
        return int'($signed(w[7:0]));
    endfunction

    // reference bresenham ordered by y (x for flat lines) that returns the pixel count
    function automatic int draw_model(input int xs, ys, xe, ye, c);
        int xa, ya, xb, yb, dx, dy, err, e2, x, y, n;
        if ((ys > ye) || (ys == ye && xs > xe)) begin
            xa = xe;
            ya = ye;
            xb = xs;
            yb = ys;
        end else begin
            xa = xs;
            ya = ys;
            xb = xe;
            yb = ye;
        end
        dx = (xb > xa) ? xb - xa : xa - xb;
        dy = ya - yb;
        err = dx + dy;
        x = xa;
        y = ya;
        n = 0;
        forever begin
            n++;
            if (x >= 0 && x < `FB_WIDTH && y >= 0 && y < `FB_HEIGHT)
                shadow[y * `FB_WIDTH + x] = c;  // clipped pixels vanish
            if (x == xb && y == yb) break;
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x += (xb > xa) ? 1 : -1;
            end
            if (e2 <= dx) begin
                err += dx;
                y++;
            end
        end
        return n;
    endfunction

    task automatic wait_done();
        bit seen;
        seen = 0;
        for (int i = 0; i < 300 && !seen; i++) begin
            @(negedge clk_sys);
            seen = done;
        end
        if (!seen) timed_out("done never pulsed after a line start");
    endtask

    task automatic wait_vsync_rise();
        bit prev, seen;
        prev = vsync;
        seen = 0;
        for (int i = 0; i < 3000 && !seen; i++) begin
            @(negedge clk_sys);
            seen = vsync && !prev;
            prev = vsync;
        end
        if (!seen) timed_out("no rising edge on vsync");
    endtask

    // one line command plus an optional start issued while busy
    task automatic run_line(input int p);
        int pixels;
        @(posedge clk_sys);
        start <= 1'b1;
        x0 <= draw_pkg::coord_t'(vec[p+1][7:0]);
        y0 <= draw_pkg::coord_t'(vec[p+2][7:0]);
        x1 <= draw_pkg::coord_t'(vec[p+3][7:0]);
        y1 <= draw_pkg::coord_t'(vec[p+4][7:0]);
        cidx <= draw_pkg::cidx_t'(vec[p+5]);
        @(posedge clk_sys);
        start <= 1'b0;
        if (vec[p+6] == 16'd4) begin
            @(posedge clk_sys);
            start <= 1'b1;  // dropped since the renderer is busy
            x0 <= draw_pkg::coord_t'(vec[p+7][7:0]);
            y0 <= draw_pkg::coord_t'(vec[p+8][7:0]);
            x1 <= draw_pkg::coord_t'(vec[p+9][7:0]);
            y1 <= draw_pkg::coord_t'(vec[p+10][7:0]);
            cidx <= draw_pkg::cidx_t'(vec[p+11]);
            @(posedge clk_sys);
            start <= 1'b0;
        end
        pixels = draw_model(field(vec[p+1]), field(vec[p+2]), field(vec[p+3]),
                            field(vec[p+4]), int'(vec[p+5][1:0]));
        wait_done();
        check("busy cycles", pixels + 1, busy_cycles);  // init cycle plus one per pixel
        repeat (3) @(posedge clk_sys);  // write pipeline drains
    endtask

    initial begin
        int p, n, vs_cycles, hs_rises, idx;
        bit hs_prev;
        rst_sys <= 1'b1;
        start <= 1'b0;
        x0 <= '0;
        y0 <= '0;
        x1 <= '0;
        y1 <= '0;
        cidx <= '0;
        pal_we <= 1'b0;
        pal_idx <= '0;
        pal_colr <= '0;
        foreach (shadow[i]) shadow[i] = 0;  // memories power up as zero
        foreach (pal_model[i]) pal_model[i] = '0;
        $readmemh("verif/line_vectors.txt", vec);
        repeat (16) @(posedge clk_sys);
        rst_sys <= 1'b0;

        p = 0;
        while (vec[p] != 16'd0 && p < 240) begin
            case (vec[p])
                16'd1: begin  // palette entry
                    @(posedge clk_sys);
                    pal_we <= 1'b1;
                    pal_idx <= draw_pkg::cidx_t'(vec[p+1]);
                    pal_colr <= display_pkg::colr_t'(vec[p+2]);
                    pal_model[vec[p+1][1:0]] = vec[p+2][11:0];
                    @(posedge clk_sys);
                    pal_we <= 1'b0;
                    p += 3;
                end
                16'd2: begin
                    run_line(p);
                    p += (vec[p+6] == 16'd4) ? 12 : 6;
                end
                16'd3: p += 4;  // probes are checked after capture
                default: begin
                    $display("bad record type %0h at word %0d", vec[p], p);
                    $display("Regression failed");
                    $fatal(1, "stopped on bad vector file");
                end
            endcase
        end

        wait_vsync_rise();
        wait_vsync_rise();
        n = 0;
        vs_cycles = 0;
        hs_rises = 0;
        hs_prev = hsync;
        for (int c = 0; c < 1120; c++) begin  // one whole frame from vsync
            if (c > 0) @(negedge clk_sys);
            if (vsync) vs_cycles++;
            if (hsync && !hs_prev) hs_rises++;
            hs_prev = hsync;
            if (de) begin
                if (n < `FB_PIXELS) frame[n] = {r, g, b};
                n++;
            end
        end
        @(negedge clk_sys);
        check("frame length", 1, vsync);
        check("de cycles", `FB_PIXELS, n);
        check("rows per frame", `V_TOTAL, hs_rises);
        check("vsync width", `H_TOTAL, vs_cycles);

        for (int i = 0; i < `FB_PIXELS; i++)
            check($sformatf("pixel %0d,%0d", i % `FB_WIDTH, i / `FB_WIDTH),
                  pal_model[shadow[i]], frame[i]);

        p = 0;
        while (vec[p] != 16'd0 && p < 240) begin
            case (vec[p])
                16'd1: p += 3;
                16'd2: p += (vec[p+6] == 16'd4) ? 12 : 6;
                default: begin  // probe
                    idx = field(vec[p+2]) * `FB_WIDTH + field(vec[p+1]);
                    check($sformatf("probe %0d,%0d", field(vec[p+1]), field(vec[p+2])),
                          vec[p+3][11:0], frame[idx]);
                    p += 4;
                end
            endcase
        end

        check("assertion failures", 0, dut0.chk0.fail_count);  // bound checker tally

        $display("Regression passed");
        $finish;
    end
endmodule

/* verif/line_vectors.txt */
// hex words: type then fields. 1 idx colr | 2 x0 y0 x1 y1 cidx | 4 x0 y0 x1 y1 cidx
// (4 is started while the line before it is busy) | 3 x y colr (probe) | 0 end
1 0 123
1 1 f00
1 2 0f0
1 3 00f
2 2 1 c 1 1
4 0 0 1f 0 2
2 14 2 14 a 2
2 8 14 0 c 3
2 18 3 1b 14 1
2 a 16 1e f 2
2 fc 5 6 5 3
3 1f 17 123  3 10 0 123
3 0 0 123    3 2 1 f00
3 c 1 f00    3 7 1 f00
3 7 0 123    3 7 2 123
3 d 1 123    3 14 2 0f0
3 14 a 0f0   3 14 6 0f0
3 15 6 123   3 14 b 123
3 0 c 00f    3 4 10 00f
3 8 14 00f   3 5 10 123
3 18 3 f00   3 1b 14 f00
3 a 16 0f0   3 1e f 0f0
3 0 5 00f    3 6 5 00f
3 3 5 00f    3 7 5 123
3 1f 5 123   3 1f 4 123
3 1f c 123   3 1c c 123
0

/* vlog.f */
+incdir+include
src/draw_pkg.sv
src/display_pkg.sv
src/bram_sdp.sv
src/render_line.sv
src/bitmap_addr.sv
src/display_scan.sv
src/line_demo_top.sv
verif/line_demo_chk.sv
verif/line_demo_tb.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= line_demo_tb
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
